// File: src/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ==================================================
// cache geometry
// ==================================================

// physical fetch address width in bits
`define ICACHE_ADDR_W 32

// associativity, tree plru assumes four
`define ICACHE_WAYS 4

// number of sets per way
`define ICACHE_SETS 16

// ==================================================
// line, beat and word sizes in bytes
// ==================================================

// one cache line
`define ICACHE_LINE_BYTES 32
// one memory response beat
`define ICACHE_BEAT_BYTES 8
// one fetched instruction word
`define ICACHE_WORD_BYTES 4

`endif

// File: src/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

  // address field widths
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_BYTES);
  localparam int SET_W    = $clog2(`ICACHE_SETS);
  localparam int TAG_W    = `ICACHE_ADDR_W - SET_W - OFFSET_W;

  // beats per line and beat index width
  localparam int BEATS  = `ICACHE_LINE_BYTES / `ICACHE_BEAT_BYTES;
  localparam int BEAT_W = $clog2(BEATS);

  // lsb of beat index and word select inside the address
  localparam int BEAT_LSB = $clog2(`ICACHE_BEAT_BYTES);
  localparam int WORD_LSB = $clog2(`ICACHE_WORD_BYTES);

  // way index width
  localparam int WAY_W = $clog2(`ICACHE_WAYS);

  typedef logic [`ICACHE_ADDR_W-1:0]         addr_t;
  typedef logic [TAG_W-1:0]                  tag_t;
  typedef logic [SET_W-1:0]                  set_t;
  typedef logic [8*`ICACHE_BEAT_BYTES-1:0]   beat_t;
  typedef logic [8*`ICACHE_WORD_BYTES-1:0]   word_t;
  typedef logic [WAY_W-1:0]                  way_t;
  // data ram address, set above beat
  typedef logic [SET_W+BEAT_W-1:0]           data_idx_t;

endpackage

// File: src/icache_ram.sv
`timescale 1ns/1ps

module icache_ram #(
  parameter type entry_t = logic [7:0],
  parameter int  DEPTH   = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     rd_en_i,
  input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
  input  logic                     wr_en_i,
  input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
  input  entry_t                   wr_data_i,
  output entry_t                   rd_data_o
);

  // storage, no reset on the array itself
  entry_t mem_q [DEPTH];

  // single write port
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_idx_i] <= wr_data_i;
    end
  end

  // registered read, holds value when not enabled
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= mem_q[rd_idx_i];
    end
  end

endmodule

// File: src/icache_way.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_way
  import icache_pkg::*;
#(
  parameter way_t WAY_ID = '0
) (
  input  logic              clk_i,
  input  logic              rst_i,
  // lookup side
  input  logic              rd_en_i,
  input  set_t              rd_set_i,
  input  logic [BEAT_W-1:0] rd_beat_i,
  input  tag_t              cmp_tag_i,
  // refill side
  input  way_t              wr_sel_i,
  input  logic              wr_beat_en_i,
  input  data_idx_t         wr_idx_i,
  input  beat_t             wr_data_i,
  input  logic              tag_wr_i,
  input  set_t              wr_set_i,
  input  tag_t              wr_tag_i,
  input  logic              flush_clr_i,
  // results
  output logic              hit_o,
  output logic              valid_o,
  output beat_t             rd_data_o
);

  logic [`ICACHE_SETS-1:0] valid_q;
  logic                    rd_valid_q;
  tag_t                    rd_tag;
  logic                    way_sel;
  logic                    data_we;
  logic                    tag_we;

  // writes only land in the way picked as victim
  assign way_sel = (wr_sel_i == WAY_ID);
  assign data_we = way_sel && wr_beat_en_i;
  assign tag_we  = way_sel && tag_wr_i;

  // ==================================================
  // tag and data arrays
  // ==================================================

  icache_ram #(
    .entry_t (tag_t),
    .DEPTH   (`ICACHE_SETS)
  ) u_tag_ram (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_en_i   (rd_en_i),
    .rd_idx_i  (rd_set_i),
    .wr_en_i   (tag_we),
    .wr_idx_i  (wr_set_i),
    .wr_data_i (wr_tag_i),
    .rd_data_o (rd_tag)
  );

  // data indexed by set then beat
  icache_ram #(
    .entry_t (beat_t),
    .DEPTH   (`ICACHE_SETS * BEATS)
  ) u_data_ram (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_en_i   (rd_en_i),
    .rd_idx_i  ({rd_set_i, rd_beat_i}),
    .wr_en_i   (data_we),
    .wr_idx_i  (wr_idx_i),
    .wr_data_i (wr_data_i),
    .rd_data_o (rd_data_o)
  );

  // valid bits, cleared by flush, set with the tag
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else if (flush_clr_i) begin
      valid_q <= '0;
    end else if (tag_we) begin
      valid_q[wr_set_i] <= 1'b1;
    end
  end

  // valid read flopped in step with the tag ram
  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      rd_valid_q <= 1'b0;
    end else if (rd_en_i) begin
      rd_valid_q <= valid_q[rd_set_i];
    end
  end

  assign valid_o = rd_valid_q;
  assign hit_o   = rd_valid_q && (rd_tag == cmp_tag_i);

endmodule

// File: src/icache_plru.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_plru
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  set_t                    set_i,
  input  logic [`ICACHE_WAYS-1:0] valid_i,
  input  logic                    hit_i,
  input  way_t                    hit_way_i,
  output way_t                    victim_o
);

  // root bit picks a half, leaf bit picks a way inside it
  logic [`ICACHE_SETS-1:0]      root_q;
  logic [`ICACHE_SETS-1:0][1:0] leaf_q;

  logic       root;
  logic [1:0] leaf;
  logic       inv_found;
  way_t       inv_way;
  way_t       lru_way;

  // ==================================================
  // state update on lookup hit
  // ==================================================

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      root_q <= '0;
      leaf_q <= '0;
    end else if (hit_i) begin
      // remember the most recent half and the way within it
      root_q[set_i]               <= hit_way_i[1];
      leaf_q[set_i][hit_way_i[1]] <= hit_way_i[0];
    end
  end

  // ==================================================
  // victim choice
  // ==================================================

  assign root = root_q[set_i];
  assign leaf = leaf_q[set_i];

  // lowest numbered invalid way wins, scan from the top
  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_found = 1'b1;
        inv_way   = way_t'(w);
      end
    end
  end

  // opposite half, then opposite of that half's leaf
  assign lru_way  = {~root, ~leaf[~root]};
  assign victim_o = inv_found ? inv_way : lru_way;

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,
  // fetch side
  input  logic                    fetch_req_i,
  input  addr_t                   fetch_addr_i,
  output logic                    fetch_ready_o,
  output logic                    fetch_valid_o,
  output word_t                   fetch_data_o,
  // flush
  input  logic                    flush_i,
  output logic                    flush_done_o,
  // memory request and response
  output logic                    mem_a_valid_o,
  output addr_t                   mem_a_addr_o,
  input  logic                    mem_a_ready_i,
  input  logic                    mem_d_valid_i,
  input  beat_t                   mem_d_data_i,
  output logic                    mem_d_ready_o,
  // way array control
  output logic                    rd_en_o,
  output set_t                    rd_set_o,
  output logic [BEAT_W-1:0]       rd_beat_o,
  output tag_t                    cmp_tag_o,
  output way_t                    wr_sel_o,
  output logic                    wr_beat_en_o,
  output data_idx_t               wr_idx_o,
  output beat_t                   wr_data_o,
  output logic                    tag_wr_o,
  output logic                    flush_clr_o,
  input  logic [`ICACHE_WAYS-1:0] way_hit_i,
  input  beat_t                   way_data_i [`ICACHE_WAYS],
  // replacement unit
  input  way_t                    victim_i,
  output logic                    plru_hit_o,
  output way_t                    hit_way_o
);

  typedef enum logic [2:0] {IDLE, LOOKUP, MISS_REQ, REFILL, REREAD} state_e;

  state_e            state_q;
  state_e            state_d;
  addr_t             addr_q;
  way_t              victim_q;
  logic [BEAT_W-1:0] beat_cnt_q;
  logic              lookup_hit;
  logic              victim_ld;
  beat_t             hit_beat;

  // ==================================================
  // hit detect and word select
  // ==================================================

  assign lookup_hit = |way_hit_i;

  // one-hot hit vector to index
  always_comb begin
    hit_way_o = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (way_hit_i[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign hit_beat     = way_data_i[hit_way_o];
  // word half picked by address bit 2
  assign fetch_data_o = hit_beat[addr_q[WORD_LSB]*$bits(word_t) +: $bits(word_t)];

  // array reads use the new fetch when accepting, else the latched one
  assign rd_set_o  = fetch_ready_o ? fetch_addr_i[OFFSET_W +: SET_W]
                                   : addr_q[OFFSET_W +: SET_W];
  assign rd_beat_o = fetch_ready_o ? fetch_addr_i[BEAT_LSB +: BEAT_W]
                                   : addr_q[BEAT_LSB +: BEAT_W];
  assign cmp_tag_o = addr_q[`ICACHE_ADDR_W-1 -: TAG_W];

  // refill writes into the latched victim
  assign wr_sel_o     = victim_q;
  assign wr_idx_o     = {addr_q[OFFSET_W +: SET_W], beat_cnt_q};
  assign wr_data_o    = mem_d_data_i;
  assign mem_a_addr_o = {addr_q[`ICACHE_ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // ==================================================
  // fetch fsm
  // ==================================================

  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    flush_done_o  = 1'b0;
    flush_clr_o   = 1'b0;
    mem_a_valid_o = 1'b0;
    mem_d_ready_o = 1'b0;
    rd_en_o       = 1'b0;
    wr_beat_en_o  = 1'b0;
    tag_wr_o      = 1'b0;
    plru_hit_o    = 1'b0;
    victim_ld     = 1'b0;
    case (state_q)
      IDLE: begin
        // flush only from idle, done in the same cycle
        if (flush_i) begin
          flush_clr_o  = 1'b1;
          flush_done_o = 1'b1;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
            state_d = LOOKUP;
          end
        end
      end
      LOOKUP: begin
        if (lookup_hit) begin
          fetch_valid_o = 1'b1;
          plru_hit_o    = 1'b1;
          // next fetch may follow straight away
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            rd_en_o = 1'b1;
          end else begin
            state_d = IDLE;
          end
        end else begin
          // miss, request goes out now
          mem_a_valid_o = 1'b1;
          victim_ld     = 1'b1;
          state_d       = mem_a_ready_i ? REFILL : MISS_REQ;
        end
      end
      MISS_REQ: begin
        mem_a_valid_o = 1'b1;
        if (mem_a_ready_i) begin
          state_d = REFILL;
        end
      end
      REFILL: begin
        mem_d_ready_o = 1'b1;
        if (mem_d_valid_i) begin
          wr_beat_en_o = 1'b1;
          // tag and valid with the last beat
          if (beat_cnt_q == BEAT_W'(BEATS - 1)) begin
            tag_wr_o = 1'b1;
            state_d  = REREAD;
          end
        end
      end
      REREAD: begin
        // re-read the filled line, hit follows in lookup
        rd_en_o = 1'b1;
        state_d = LOOKUP;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_i) begin
    if (!rst_i) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // wraps back to zero after the last beat
      if (wr_beat_en_o) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
    end
  end

  // request address and victim
  always_ff @(posedge clk_i) begin
    if (fetch_req_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
    end
    if (victim_ld) begin
      victim_q <= victim_i;
    end
  end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  // fetch
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output word_t fetch_data_o,
  // flush
  input  logic  flush_i,
  output logic  flush_done_o,
  // memory request
  output logic  mem_a_valid_o,
  output addr_t mem_a_addr_o,
  input  logic  mem_a_ready_i,
  // memory response
  input  logic  mem_d_valid_i,
  input  beat_t mem_d_data_i,
  output logic  mem_d_ready_o
);

  // broadcast to every way
  logic              rd_en;
  set_t              rd_set;
  logic [BEAT_W-1:0] rd_beat;
  tag_t              cmp_tag;
  way_t              wr_sel;
  logic              wr_beat_en;
  data_idx_t         wr_idx;
  beat_t             wr_data;
  logic              tag_wr;
  logic              flush_clr;

  // returned by the ways
  logic [`ICACHE_WAYS-1:0] way_hit;
  logic [`ICACHE_WAYS-1:0] way_valid;
  beat_t                   way_data [`ICACHE_WAYS];

  // replacement unit
  logic plru_hit;
  way_t hit_way;
  way_t victim;

  // ==================================================
  // controller
  // ==================================================

  icache_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .flush_i       (flush_i),
    .flush_done_o  (flush_done_o),
    .mem_a_valid_o (mem_a_valid_o),
    .mem_a_addr_o  (mem_a_addr_o),
    .mem_a_ready_i (mem_a_ready_i),
    .mem_d_valid_i (mem_d_valid_i),
    .mem_d_data_i  (mem_d_data_i),
    .mem_d_ready_o (mem_d_ready_o),
    .rd_en_o       (rd_en),
    .rd_set_o      (rd_set),
    .rd_beat_o     (rd_beat),
    .cmp_tag_o     (cmp_tag),
    .wr_sel_o      (wr_sel),
    .wr_beat_en_o  (wr_beat_en),
    .wr_idx_o      (wr_idx),
    .wr_data_o     (wr_data),
    .tag_wr_o      (tag_wr),
    .flush_clr_o   (flush_clr),
    .way_hit_i     (way_hit),
    .way_data_i    (way_data),
    .victim_i      (victim),
    .plru_hit_o    (plru_hit),
    .hit_way_o     (hit_way)
  );

  // set of the latched request comes from the refill index
  icache_plru u_plru (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .set_i     (wr_idx[BEAT_W +: SET_W]),
    .valid_i   (way_valid),
    .hit_i     (plru_hit),
    .hit_way_i (hit_way),
    .victim_o  (victim)
  );

  // ==================================================
  // ways
  // ==================================================

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_way #(
      .WAY_ID (way_t'(w))
    ) u_way (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .rd_en_i      (rd_en),
      .rd_set_i     (rd_set),
      .rd_beat_i    (rd_beat),
      .cmp_tag_i    (cmp_tag),
      .wr_sel_i     (wr_sel),
      .wr_beat_en_i (wr_beat_en),
      .wr_idx_i     (wr_idx),
      .wr_data_i    (wr_data),
      .tag_wr_i     (tag_wr),
      .wr_set_i     (wr_idx[BEAT_W +: SET_W]),
      .wr_tag_i     (cmp_tag),
      .flush_clr_i  (flush_clr),
      .hit_o        (way_hit[w]),
      .valid_o      (way_valid[w]),
      .rd_data_o    (way_data[w])
    );
  end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // active low reset, released on a falling edge
  initial begin
    rst_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b1;
  end

endmodule

// File: sim/icache_tb.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb
  import icache_pkg::*;
();

  logic  clk_i;
  logic  rst_i;
  logic  fetch_req_i;
  addr_t fetch_addr_i;
  logic  fetch_ready_o;
  logic  fetch_valid_o;
  word_t fetch_data_o;
  logic  flush_i;
  logic  flush_done_o;
  logic  mem_a_valid_o;
  addr_t mem_a_addr_o;
  logic  mem_a_ready_i;
  logic  mem_d_valid_i;
  beat_t mem_d_data_i;
  logic  mem_d_ready_o;

  // reference model of tags, valid bits and tree plru
  tag_t       tag_m   [`ICACHE_WAYS][`ICACHE_SETS];
  logic       valid_m [`ICACHE_WAYS][`ICACHE_SETS];
  logic       root_m  [`ICACHE_SETS];
  logic [1:0] leaf_m  [`ICACHE_SETS];
  addr_t      evict_line;

  // expected responses in acceptance order
  word_t exp_word_q [$];
  logic  exp_hit_q  [$];
  int    acc_cyc_q  [$];
  addr_t exp_line_q [$];
  // lines the memory still owes beats for
  addr_t pend_q     [$];

  logic [31:0] lfsr_q;
  int          cycle_cnt;
  int          issued_cnt;
  int          beat_idx;
  logic        stall_en;
  logic        a_rdy_nx;
  logic        d_vld_nx;
  beat_t       d_data_nx;
  string       test_name;

  tb_clk_gen #(
    .PERIOD_NS  (40),
    .RST_CYCLES (10)
  ) u_clk_gen (
    .clk_o (clk_i),
    .rst_o (rst_i)
  );

  icache_top DUT (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .flush_i       (flush_i),
    .flush_done_o  (flush_done_o),
    .mem_a_valid_o (mem_a_valid_o),
    .mem_a_addr_o  (mem_a_addr_o),
    .mem_a_ready_i (mem_a_ready_i),
    .mem_d_valid_i (mem_d_valid_i),
    .mem_d_data_i  (mem_d_data_i),
    .mem_d_ready_o (mem_d_ready_o)
  );

  // ==================================================
  // reference functions
  // ==================================================

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  // base plus random tag low bits and a random set 0..3 and word
  function automatic addr_t rand_addr(input addr_t base, input int tag_bits);
    addr_t a;
    a = base | (rand_bits(tag_bits) << (OFFSET_W + SET_W));
    a = a | (rand_bits(2) << OFFSET_W);
    a = a | (rand_bits(3) << WORD_LSB);
    return a;
  endfunction

  function automatic addr_t line_addr(input tag_t t, input set_t s);
    return {t, s, {OFFSET_W{1'b0}}};
  endfunction

  // memory content holds the byte address low and a scrambled copy high
  function automatic beat_t mem_beat(input addr_t baddr);
    return {baddr ^ 32'h5a5a5a5a, baddr};
  endfunction

  function automatic word_t exp_word(input addr_t addr);
    beat_t beat;
    beat = mem_beat({addr[`ICACHE_ADDR_W-1:BEAT_LSB], {BEAT_LSB{1'b0}}});
    return addr[WORD_LSB] ? beat[63:32] : beat[31:0];
  endfunction

  // lookup, fill on miss, plru touch, queue the expectations
  task automatic model_access(input addr_t addr);
    set_t set_idx;
    tag_t tag;
    logic hit;
    logic found;
    way_t way;
    set_idx = addr[OFFSET_W +: SET_W];
    tag     = addr[`ICACHE_ADDR_W-1 -: TAG_W];
    hit     = 1'b0;
    found   = 1'b0;
    way     = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (valid_m[w][set_idx] && tag_m[w][set_idx] == tag) begin
        hit = 1'b1;
        way = way_t'(w);
      end
    end
    if (!hit) begin
      // lowest invalid way first
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (!found && !valid_m[w][set_idx]) begin
          found = 1'b1;
          way   = way_t'(w);
        end
      end
      if (!found) begin
        way        = {~root_m[set_idx], ~leaf_m[set_idx][~root_m[set_idx]]};
        evict_line = line_addr(tag_m[way][set_idx], set_idx);
      end
      tag_m[way][set_idx]   = tag;
      valid_m[way][set_idx] = 1'b1;
      exp_line_q.push_back(line_addr(tag, set_idx));
    end
    // refill ends in a re-lookup hit, so plru is touched either way
    root_m[set_idx]          = way[1];
    leaf_m[set_idx][way[1]] = way[0];
    exp_word_q.push_back(exp_word(addr));
    exp_hit_q.push_back(hit);
    acc_cyc_q.push_back(cycle_cnt);
  endtask

  task automatic model_flush();
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        valid_m[w][s] = 1'b0;
      end
    end
  endtask

  // ==================================================
  // checking
  // ==================================================

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      fail_run($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                         test_name, what, exp, act));
    end
  endtask

  // compare process that also runs the memory model and the cycle limit
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > 200 * issued_cnt + 100) begin
      fail_run($sformatf("run hung in %s after %0d cycles", test_name, cycle_cnt));
    end
    // flush is only raised from idle so done pulses with it
    check_value("flush done", flush_i, flush_done_o);
    if (flush_i) begin
      model_flush();
    end
    // response first since a new fetch can be accepted in the same cycle
    if (fetch_valid_o) begin
      if (exp_word_q.size() == 0) begin
        fail_run("fetch_valid_o pulsed with no fetch outstanding");
      end else begin
        check_value("fetch word", exp_word_q.pop_front(), fetch_data_o);
        check_value("hit latency of one", exp_hit_q.pop_front(),
                    (cycle_cnt - acc_cyc_q.pop_front()) == 1);
      end
    end
    // ready when nothing is outstanding and no flush is taken
    check_value("fetch ready", exp_word_q.size() == 0 && !flush_i, fetch_ready_o);
    if (fetch_req_i && fetch_ready_o) begin
      model_access(fetch_addr_i);
    end
    // beats are taken only while a line is owed
    check_value("refill ready", pend_q.size() != 0, mem_d_ready_o);
    if (mem_a_valid_o && mem_a_ready_i) begin
      if (exp_line_q.size() == 0) begin
        fail_run("memory request issued although every fetch should hit");
      end else begin
        check_value("line address", exp_line_q.pop_front(), mem_a_addr_o);
        pend_q.push_back(mem_a_addr_o);
      end
    end
    if (mem_d_valid_i && mem_d_ready_o) begin
      beat_idx = beat_idx + 1;
      if (beat_idx == BEATS) begin
        void'(pend_q.pop_front());
        beat_idx = 0;
      end
    end
    // next memory drive with stalls only when enabled
    a_rdy_nx = stall_en ? lfsr_step() : 1'b1;
    if (pend_q.size() != 0) begin
      d_vld_nx  = stall_en ? lfsr_step() : 1'b1;
      d_data_nx = mem_beat(pend_q[0] + addr_t'(beat_idx * `ICACHE_BEAT_BYTES));
    end else begin
      d_vld_nx = 1'b0;
    end
  end

  always @(negedge clk_i) begin
    mem_a_ready_i = a_rdy_nx;
    mem_d_valid_i = d_vld_nx;
    mem_d_data_i  = d_data_nx;
  end

  // ==================================================
  // stimulus
  // ==================================================

  // called on a falling edge and returns on the falling edge after acceptance
  task automatic issue_fetch(input addr_t addr);
    fetch_req_i  = 1'b1;
    fetch_addr_i = addr;
    issued_cnt   = issued_cnt + 1;
    @(posedge clk_i);
    while (!fetch_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    fetch_req_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_word_q.size() != 0) @(negedge clk_i);
  endtask

  // flush_i held until the done pulse
  task automatic flush_cache();
    flush_i = 1'b1;
    @(posedge clk_i);
    while (!flush_done_o) @(posedge clk_i);
    @(negedge clk_i);
    flush_i = 1'b0;
  endtask

  initial begin
    fetch_req_i   = 1'b0;
    fetch_addr_i  = '0;
    flush_i       = 1'b0;
    mem_a_ready_i = 1'b0;
    mem_d_valid_i = 1'b0;
    mem_d_data_i  = '0;
    lfsr_q        = 32'h416f;
    cycle_cnt     = 0;
    issued_cnt    = 0;
    beat_idx      = 0;
    stall_en      = 1'b0;
    a_rdy_nx      = 1'b0;
    d_vld_nx      = 1'b0;
    d_data_nx     = '0;
    test_name     = "reset";
    model_flush();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      root_m[s] = 1'b0;
      leaf_m[s] = 2'b00;
    end
    @(posedge rst_i);
    @(negedge clk_i);

    // cold miss then every word of the filled line
    test_name = "cold_miss";
    issue_fetch(32'h0000_1004);
    wait_idle();
    test_name = "line_hit";
    for (int i = 0; i < 8; i++) begin
      issue_fetch(32'h0000_1000 + addr_t'(4 * i));
    end
    wait_idle();

    // fill sets 0..3 then stream random hits
    test_name = "stream_hits";
    for (int i = 0; i < 4; i++) begin
      issue_fetch(32'h0002_0000 + addr_t'(i << OFFSET_W));
    end
    for (int i = 0; i < 40; i++) begin
      issue_fetch(rand_addr(32'h0002_0000, 0));
    end
    wait_idle();

    // five tags in set 5 with ways 2 and 0 touched before the fifth
    test_name = "plru_evict";
    for (int i = 0; i < 4; i++) begin
      issue_fetch(line_addr(tag_t'(64 + i), set_t'(5)));
    end
    issue_fetch(line_addr(tag_t'(66), set_t'(5)) | 32'h8);
    issue_fetch(line_addr(tag_t'(64), set_t'(5)) | 32'h14);
    issue_fetch(line_addr(tag_t'(68), set_t'(5)) | 32'h4);
    wait_idle();
    // survivors hit and the evicted line misses last
    for (int i = 0; i < 5; i++) begin
      if (line_addr(tag_t'(64 + i), set_t'(5)) != evict_line) begin
        issue_fetch(line_addr(tag_t'(64 + i), set_t'(5)) | 32'hc);
      end
    end
    issue_fetch(evict_line | 32'h1c);
    wait_idle();

    // flush then the first line is gone
    test_name = "flush";
    flush_cache();
    issue_fetch(32'h0000_1008);
    wait_idle();

    // misses and hits with random memory stalls
    test_name = "mem_stall";
    stall_en = 1'b1;
    for (int i = 0; i < 30; i++) begin
      issue_fetch(rand_addr(32'h0008_0000, 3));
    end
    wait_idle();
    stall_en = 1'b0;

    @(negedge clk_i);
    if (exp_line_q.size() != 0 || pend_q.size() != 0) begin
      fail_run("memory request or refill beats still outstanding at the end");
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

// File: verilog.f
+incdir+src
src/icache_pkg.sv
src/icache_ram.sv
src/icache_way.sv
src/icache_plru.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/tb_clk_gen.sv
sim/icache_tb.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/icache_pkg.sv
      - src/icache_ram.sv
      - src/icache_way.sv
      - src/icache_plru.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - sim/tb_clk_gen.sv
      - sim/icache_tb.sv
